// ==== logic/gcn_defs.svh ====
`ifndef GCN_DEFS_SVH
`define GCN_DEFS_SVH

// graph and problem size
`define GCN_NUM_NODES      6
`define GCN_NUM_EDGES      6
`define GCN_NUM_CLASSES    3
`define GCN_NUM_FEATURES   96

// value widths, all unsigned
`define GCN_FEAT_W         5
`define GCN_WEIGHT_W       5

// five neighbours of 31 at most
`define GCN_AGG_W          10

// 96 products of 155 x 31 still fit
`define GCN_ACC_W          21

// memory address and edge entry widths
`define GCN_ADDR_W         7
`define GCN_NODE_W         3

`endif

// ==== logic/gcn_ctrl_pkg.sv ====
`default_nettype none

`include "gcn_defs.svh"

package gcn_ctrl_pkg;

    // top level sequence, one pass per start
    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_build,
        st_stream,
        st_drain,
        st_scan,
        st_write,
        st_finish
    } ctrl_state_e;

    typedef logic [$clog2(`GCN_NUM_EDGES)-1:0]   edge_idx_t;
    typedef logic [$clog2(`GCN_NUM_CLASSES)-1:0] class_idx_t;
    typedef logic [`GCN_ADDR_W-1:0]              feat_addr_t;

endpackage

`default_nettype wire

// ==== logic/gcn_data_pkg.sv ====
`default_nettype none

`include "gcn_defs.svh"

package gcn_data_pkg;

    // scalar values
    typedef logic [`GCN_FEAT_W-1:0]   feat_t;
    typedef logic [`GCN_WEIGHT_W-1:0] weight_t;
    typedef logic [`GCN_AGG_W-1:0]    agg_t;
    typedef logic [`GCN_ACC_W-1:0]    score_t;
    typedef logic [`GCN_NODE_W-1:0]   node_id_t;

    // one feature for all nodes, indexed by node
    typedef feat_t [`GCN_NUM_NODES-1:0] feat_col_t;

    // one feature's weight for each class
    typedef weight_t [`GCN_NUM_CLASSES-1:0] weight_row_t;

    // row 0 holds the source ends, row 1 the destination ends
    typedef node_id_t [1:0][`GCN_NUM_EDGES-1:0] coo_t;

    // adj_mat[n][m] set when m is a neighbour of n
    typedef logic [`GCN_NUM_NODES-1:0][`GCN_NUM_NODES-1:0] adj_mat_t;

    typedef agg_t [`GCN_NUM_NODES-1:0] agg_vec_t;
    typedef score_t [`GCN_NUM_NODES-1:0][`GCN_NUM_CLASSES-1:0] score_mat_t;
    typedef gcn_ctrl_pkg::class_idx_t [`GCN_NUM_NODES-1:0] class_vec_t;

endpackage

`default_nettype wire

// ==== logic/gcn_ctrl.sv ====
`default_nettype none

`include "gcn_defs.svh"

module gcn_ctrl (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start,
    output logic                          load_coo,
    output logic                          acc_clear,
    output logic                          edge_en,
    output gcn_ctrl_pkg::edge_idx_t       edge_idx,
    output logic                          input_re,
    output gcn_ctrl_pkg::feat_addr_t      input_addr,
    output logic                          scan_en,
    output gcn_ctrl_pkg::class_idx_t      scan_class,
    output logic                          output_we,
    output logic                          done
);

    import gcn_ctrl_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    feat_addr_t  step;
    logic        step_last;

    //////////////////////////////
    // step counter
    //////////////////////////////

    // terminal count per state, single cycle states end at once
    always_comb begin
        case (state)
            st_build:  step_last = (step == feat_addr_t'(`GCN_NUM_EDGES - 1));
            st_stream: step_last = (step == feat_addr_t'(`GCN_NUM_FEATURES - 1));
            // two stages between memory and accumulators
            st_drain:  step_last = (step == feat_addr_t'(1));
            st_scan:   step_last = (step == feat_addr_t'(`GCN_NUM_CLASSES - 1));
            default:   step_last = 1'b1;
        endcase
    end

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) state_nxt = st_load;
            end
            st_load:   state_nxt = st_build;
            st_build: begin
                if (step_last) state_nxt = st_stream;
            end
            st_stream: begin
                if (step_last) state_nxt = st_drain;
            end
            st_drain: begin
                if (step_last) state_nxt = st_scan;
            end
            st_scan: begin
                if (step_last) state_nxt = st_write;
            end
            st_write:  state_nxt = st_finish;
            // hold done until the next run
            st_finish: begin
                if (start) state_nxt = st_load;
            end
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            state <= state_nxt;
            if (step_last) begin
                step <= '0;
            end else begin
                step <= step + feat_addr_t'(1);
            end
        end
    end

    //////////////////////////////
    // output decode
    //////////////////////////////

    assign load_coo   = (state == st_load);
    assign acc_clear  = (state == st_load);
    assign edge_en    = (state == st_build);
    assign edge_idx   = edge_idx_t'(step);
    assign input_re   = (state == st_stream);
    assign input_addr = step;
    assign scan_en    = (state == st_scan);
    assign scan_class = class_idx_t'(step);
    assign output_we  = (state == st_write);
    assign done       = (state == st_finish);

endmodule

`default_nettype wire

// ==== logic/adj_builder.sv ====
`default_nettype none

`include "gcn_defs.svh"

module adj_builder (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     load_coo,
    input  wire gcn_data_pkg::coo_t       coo_mat,
    input  wire logic                     edge_en,
    input  wire gcn_ctrl_pkg::edge_idx_t  edge_idx,
    output gcn_data_pkg::adj_mat_t        adj_mat
);

    import gcn_data_pkg::*;

    coo_t     coo_q;
    node_id_t src;
    node_id_t dst;
    node_id_t src_row;
    node_id_t dst_row;
    logic     edge_ok;

    // edge list, held for the build pass
    always_ff @(posedge clk) begin
        if (load_coo) begin
            coo_q <= coo_mat;
        end
    end

    assign src = coo_q[0][edge_idx];
    assign dst = coo_q[1][edge_idx];

    // node numbers are one based
    assign src_row = src - node_id_t'(1);
    assign dst_row = dst - node_id_t'(1);

    // 0 and 7 name no node
    assign edge_ok = (src != '0) && (src != '1) && (dst != '0) && (dst != '1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj_mat <= '0;
        end else if (load_coo) begin
            adj_mat <= '0;
        end else if (edge_en && edge_ok) begin
            adj_mat[src_row][dst_row] <= 1'b1;
            adj_mat[dst_row][src_row] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/feat_aggregator.sv ====
`default_nettype none

`include "gcn_defs.svh"

module feat_aggregator (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        input_re,
    input  wire gcn_data_pkg::adj_mat_t      adj_mat,
    input  wire gcn_data_pkg::feat_col_t     col_features,
    input  wire gcn_data_pkg::weight_row_t   row_weights,
    output gcn_data_pkg::agg_vec_t           agg_vec,
    output gcn_data_pkg::weight_row_t        weights_q,
    output logic                             agg_valid
);

    import gcn_data_pkg::*;

    logic     rd_valid;
    agg_vec_t agg_sum;

    // memory answers one cycle after the read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            agg_valid <= 1'b0;
        end else begin
            rd_valid  <= input_re;
            agg_valid <= rd_valid;
        end
    end

    //////////////////////////////
    // neighbour sums
    //////////////////////////////

    // adjacency row masks the column without the node itself
    always_comb begin
        agg_sum = '0;
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            for (int m = 0; m < `GCN_NUM_NODES; m++) begin
                if (adj_mat[n][m] && (m != n)) begin
                    agg_sum[n] = agg_sum[n] + agg_t'(col_features[m]);
                end
            end
        end
    end

    // weight row travels with its aggregates
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            agg_vec   <= agg_sum;
            weights_q <= row_weights;
        end
    end

endmodule

`default_nettype wire

// ==== logic/transform_accum.sv ====
`default_nettype none

`include "gcn_defs.svh"

module transform_accum (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        acc_clear,
    input  wire logic                        agg_valid,
    input  wire gcn_data_pkg::agg_vec_t      agg_vec,
    input  wire gcn_data_pkg::weight_row_t   weights_q,
    output gcn_data_pkg::score_mat_t         scores
);

    import gcn_data_pkg::*;

    localparam int ProdW = `GCN_AGG_W + `GCN_WEIGHT_W;

    logic [`GCN_NUM_NODES-1:0][`GCN_NUM_CLASSES-1:0][ProdW-1:0] prod;

    //////////////////////////////
    // per feature transform
    //////////////////////////////

    // node aggregate times class weight, full width product
    always_comb begin
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            for (int c = 0; c < `GCN_NUM_CLASSES; c++) begin
                prod[n][c] = agg_vec[n] * weights_q[c];
            end
        end
    end

    //////////////////////////////
    // score accumulators
    //////////////////////////////

    // 18 running sums, one per node and class
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
        end else if (acc_clear) begin
            scores <= '0;
        end else if (agg_valid) begin
            for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                for (int c = 0; c < `GCN_NUM_CLASSES; c++) begin
                    scores[n][c] <= scores[n][c] + score_t'(prod[n][c]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/argmax_classifier.sv ====
`default_nettype none

`include "gcn_defs.svh"

module argmax_classifier (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        scan_en,
    input  wire gcn_ctrl_pkg::class_idx_t    scan_class,
    input  wire gcn_data_pkg::score_mat_t    scores,
    input  wire logic                        output_we,
    output gcn_data_pkg::class_vec_t         y
);

    import gcn_data_pkg::*;

    score_t [`GCN_NUM_NODES-1:0] cand;
    score_t [`GCN_NUM_NODES-1:0] best_score;
    class_vec_t                  best_idx;

    // score of the class under scan, for every node
    always_comb begin
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            cand[n] = scores[n][scan_class];
        end
    end

    //////////////////////////////
    // class scan
    //////////////////////////////

    // class 0 seeds the pair, a tie keeps the lower index
    always_ff @(posedge clk) begin
        if (scan_en) begin
            for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                if ((scan_class == '0) || (cand[n] > best_score[n])) begin
                    best_score[n] <= cand[n];
                    best_idx[n]   <= scan_class;
                end
            end
        end
    end

    //////////////////////////////
    // result register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (output_we) begin
            y <= best_idx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/gcn_top.sv ====
`default_nettype none

`include "gcn_defs.svh"

module gcn_top (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        start,
    input  wire gcn_data_pkg::coo_t          coo_mat,
    input  wire gcn_data_pkg::feat_col_t     col_features,
    input  wire gcn_data_pkg::weight_row_t   row_weights,
    output logic                             input_re,
    output gcn_ctrl_pkg::feat_addr_t         input_addr,
    output logic                             output_we,
    output gcn_data_pkg::class_vec_t         y,
    output logic                             done
);

    import gcn_ctrl_pkg::*;
    import gcn_data_pkg::*;

    // sequencing strobes
    logic        load_coo;
    logic        acc_clear;
    logic        edge_en;
    logic        scan_en;
    edge_idx_t   edge_idx;
    class_idx_t  scan_class;

    // datapath
    adj_mat_t    adj_mat;
    agg_vec_t    agg_vec;
    weight_row_t weights_q;
    logic        agg_valid;
    score_mat_t  scores;

    gcn_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .load_coo   (load_coo),
        .acc_clear  (acc_clear),
        .edge_en    (edge_en),
        .edge_idx   (edge_idx),
        .input_re   (input_re),
        .input_addr (input_addr),
        .scan_en    (scan_en),
        .scan_class (scan_class),
        .output_we  (output_we),
        .done       (done)
    );

    adj_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_coo (load_coo),
        .coo_mat  (coo_mat),
        .edge_en  (edge_en),
        .edge_idx (edge_idx),
        .adj_mat  (adj_mat)
    );

    feat_aggregator u_agg (
        .clk          (clk),
        .rst_n        (rst_n),
        .input_re     (input_re),
        .adj_mat      (adj_mat),
        .col_features (col_features),
        .row_weights  (row_weights),
        .agg_vec      (agg_vec),
        .weights_q    (weights_q),
        .agg_valid    (agg_valid)
    );

    transform_accum u_acc (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .agg_valid (agg_valid),
        .agg_vec   (agg_vec),
        .weights_q (weights_q),
        .scores    (scores)
    );

    argmax_classifier u_argmax (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_en    (scan_en),
        .scan_class (scan_class),
        .scores     (scores),
        .output_we  (output_we),
        .y          (y)
    );

endmodule

`default_nettype wire

// ==== verif/gcn_mem_model.sv ====
`default_nettype none

`include "gcn_defs.svh"

module gcn_mem_model (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      input_re,
    input  wire gcn_ctrl_pkg::feat_addr_t  input_addr,
    output gcn_data_pkg::feat_col_t        col_features,
    output gcn_data_pkg::weight_row_t      row_weights
);

    timeunit 1ns;
    timeprecision 1ps;

    import gcn_ctrl_pkg::*;
    import gcn_data_pkg::*;

    feat_col_t   feat_mem   [`GCN_NUM_FEATURES];
    weight_row_t weight_mem [`GCN_NUM_FEATURES];

    // loaded before each run, between runs only
    task write_entry(input feat_addr_t addr, input feat_col_t col, input weight_row_t row);
        feat_mem[addr]   = col;
        weight_mem[addr] = row;
    endtask

    // one cycle read latency, both memories share the address
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_features <= '0;
            row_weights  <= '0;
        end else if (input_re) begin
            col_features <= feat_mem[input_addr];
            row_weights  <= weight_mem[input_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verif/gcn_tb.sv ====
`default_nettype none

`include "gcn_defs.svh"

module gcn_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import gcn_ctrl_pkg::*;
    import gcn_data_pkg::*;

    localparam int DoneLatency = 109;
    localparam int WaitLimit   = 300;

    logic        clk;
    logic        rst_n;
    logic        start;
    coo_t        coo_mat;
    feat_col_t   col_features;
    weight_row_t row_weights;
    logic        input_re;
    feat_addr_t  input_addr;
    logic        output_we;
    class_vec_t  y;
    logic        done;

    integer      seed;
    int          mismatches;
    int          failures;

    // stimulus of the current run and the expected classes
    feat_t       feat_val [`GCN_NUM_FEATURES][`GCN_NUM_NODES];
    weight_t     wgt_val  [`GCN_NUM_FEATURES][`GCN_NUM_CLASSES];
    node_id_t    src_list [`GCN_NUM_EDGES];
    node_id_t    dst_list [`GCN_NUM_EDGES];
    class_idx_t  exp_y    [`GCN_NUM_NODES];

    gcn_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .coo_mat      (coo_mat),
        .col_features (col_features),
        .row_weights  (row_weights),
        .input_re     (input_re),
        .input_addr   (input_addr),
        .output_we    (output_we),
        .y            (y),
        .done         (done)
    );

    gcn_mem_model u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .input_re     (input_re),
        .input_addr   (input_addr),
        .col_features (col_features),
        .row_weights  (row_weights)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic fill_features(input bit use_max);
        int          r;
        feat_col_t   col;
        weight_row_t row;
        for (int f = 0; f < `GCN_NUM_FEATURES; f++) begin
            for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                r = $random(seed);
                feat_val[f][n] = use_max ? 5'h1f : r[4:0];
                col[n] = feat_val[f][n];
            end
            for (int c = 0; c < `GCN_NUM_CLASSES; c++) begin
                r = $random(seed);
                wgt_val[f][c] = use_max ? 5'h1f : r[4:0];
                row[c] = wgt_val[f][c];
            end
            u_mem.write_entry(feat_addr_t'(f), col, row);
        end
    endtask

    // valid ends 1 to 6 and never a self-loop
    task automatic random_edges();
        int r;
        int off;
        for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
            r = $random(seed);
            src_list[e] = node_id_t'(r[15:0] % 6 + 1);
            off = r[23:16] % 5 + 1;
            dst_list[e] = node_id_t'((int'(src_list[e]) - 1 + off) % 6 + 1);
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    task automatic compute_reference();
        bit adj   [`GCN_NUM_NODES][`GCN_NUM_NODES];
        int score [`GCN_NUM_NODES][`GCN_NUM_CLASSES];
        int agg;
        int s;
        int d;
        int best;
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            for (int m = 0; m < `GCN_NUM_NODES; m++) begin
                adj[n][m] = 1'b0;
            end
            for (int c = 0; c < `GCN_NUM_CLASSES; c++) begin
                score[n][c] = 0;
            end
        end
        for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
            s = int'(src_list[e]);
            d = int'(dst_list[e]);
            // 0 and 7 are not nodes
            if (s >= 1 && s <= 6 && d >= 1 && d <= 6) begin
                adj[s-1][d-1] = 1'b1;
                adj[d-1][s-1] = 1'b1;
            end
        end
        for (int f = 0; f < `GCN_NUM_FEATURES; f++) begin
            for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                agg = 0;
                for (int m = 0; m < `GCN_NUM_NODES; m++) begin
                    if (m != n && adj[n][m]) begin
                        agg = agg + int'(feat_val[f][m]);
                    end
                end
                for (int c = 0; c < `GCN_NUM_CLASSES; c++) begin
                    score[n][c] = score[n][c] + agg * int'(wgt_val[f][c]);
                end
            end
        end
        // strictly greater wins so ties keep the lower class
        for (int n = 0; n < `GCN_NUM_NODES; n++) begin
            exp_y[n] = '0;
            best = score[n][0];
            for (int c = 1; c < `GCN_NUM_CLASSES; c++) begin
                if (score[n][c] > best) begin
                    best = score[n][c];
                    exp_y[n] = class_idx_t'(c);
                end
            end
        end
    endtask

    //////////////////////////////
    // one run and its checks
    //////////////////////////////

    task automatic run_graph(input string name);
        int cycles;
        int re_count;
        int we_count;
        int we_cycle;
        bit seen_done;
        compute_reference();
        @(posedge clk);
        #1;
        for (int e = 0; e < `GCN_NUM_EDGES; e++) begin
            coo_mat[0][e] = src_list[e];
            coo_mat[1][e] = dst_list[e];
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start     = 1'b0;
        cycles    = 0;
        re_count  = 0;
        we_count  = 0;
        we_cycle  = -1;
        seen_done = 1'b0;
        while (!seen_done && cycles < WaitLimit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (input_re) begin
                if (int'(input_addr) != re_count) begin
                    $display("mismatch at %0t: %s input_addr %0d, expected %0d",
                             $time, name, input_addr, re_count);
                    mismatches++;
                end
                re_count++;
            end
            if (output_we) begin
                we_count++;
                we_cycle = cycles;
            end
            seen_done = done;
        end
        if (!seen_done) begin
            $display("%s: done never rose within %0d cycles of start", name, WaitLimit);
            failures++;
        end else begin
            if (cycles != DoneLatency) begin
                $display("mismatch at %0t: %s done after %0d cycles, expected %0d",
                         $time, name, cycles, DoneLatency);
                mismatches++;
            end
            if (re_count != `GCN_NUM_FEATURES) begin
                $display("mismatch at %0t: %s input_re high %0d cycles, expected %0d",
                         $time, name, re_count, `GCN_NUM_FEATURES);
                mismatches++;
            end
            if (we_count != 1 || we_cycle != cycles - 1) begin
                $display("mismatch at %0t: %s output_we %0d pulses, last at cycle %0d",
                         $time, name, we_count, we_cycle);
                mismatches++;
            end
            for (int n = 0; n < `GCN_NUM_NODES; n++) begin
                if (y[n] != exp_y[n]) begin
                    $display("mismatch at %0t: %s y[%0d] = %0d, expected %0d",
                             $time, name, n, y[n], exp_y[n]);
                    mismatches++;
                end
            end
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_values();
        if (done || output_we || input_re || y != '0) begin
            $display("mismatch at %0t: after reset done %0b output_we %0b input_re %0b y %0h",
                     $time, done, output_we, input_re, y);
            mismatches++;
        end
    endtask

    task automatic test_random_graph();
        fill_features(1'b0);
        random_edges();
        run_graph("random graph");
    endtask

    // dropped 0 and 7 ends, a repeated edge, a self-loop and an isolated node 6
    task automatic test_edge_rules();
        fill_features(1'b0);
        src_list = '{3'd1, 3'd2, 3'd0, 3'd4, 3'd3, 3'd5};
        dst_list = '{3'd2, 3'd1, 3'd3, 3'd7, 3'd4, 3'd5};
        run_graph("edge rules");
        if (y[5] != '0) begin
            $display("mismatch at %0t: isolated node y = %0d, expected 0", $time, y[5]);
            mismatches++;
        end
    endtask

    task automatic test_max_values();
        fill_features(1'b1);
        random_edges();
        run_graph("max values");
    endtask

    task automatic test_restart();
        if (!done) begin
            $display("restart test found no finished run to start from");
            failures++;
        end
        fill_features(1'b0);
        random_edges();
        run_graph("restart");
    endtask

    initial begin
        seed       = 14879;
        mismatches = 0;
        failures   = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        coo_mat    = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset_values();
        test_random_graph();
        test_edge_rules();
        test_max_values();
        test_restart();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== gcn.f ====
+incdir+logic
logic/gcn_ctrl_pkg.sv
logic/gcn_data_pkg.sv
logic/gcn_ctrl.sv
logic/adj_builder.sv
logic/feat_aggregator.sv
logic/transform_accum.sv
logic/argmax_classifier.sv
logic/gcn_top.sv
verif/gcn_mem_model.sv
verif/gcn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f gcn.f --top-module gcn_tb -Mdir obj_dir -o gcn_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/gcn_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
